// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= tb_exec_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/execute.sv
logic/mem_stage.sv
logic/exec_core.sv
tests/exec_checker.sv
tests/tb_exec_core.sv

// File: logic/alu.sv
module alu (
    input  logic [cpu_pkg::RW-1:0]     i_l,
    input  logic [cpu_pkg::RW-1:0]     i_r,
    input  cpu_pkg::alu_mode_e         i_mode,
    input  logic                       i_carry,
    output logic [cpu_pkg::RW-1:0]     o_out,
    output logic [cpu_pkg::FLAG_W-1:0] o_flags
);
    import cpu_pkg::*;

    localparam int SHAMT_W = $clog2(RW);

    // One extra bit on top holds carry or borrow
    logic [RW:0] wide;
    logic        is_add;
    logic        is_sub;
    logic        ovf_add;
    logic        ovf_sub;

    always_comb begin
        wide = '0;
        case (i_mode)
            ALU_ADD:
                wide = {1'b0, i_l} + {1'b0, i_r};
            ALU_ADC:
                wide = {1'b0, i_l} + {1'b0, i_r} + {{RW{1'b0}}, i_carry};
            ALU_SUB:
                wide = {1'b0, i_l} - {1'b0, i_r};
            ALU_SBC:
                wide = {1'b0, i_l} - {1'b0, i_r} - {{RW{1'b0}}, i_carry};
            ALU_AND:
                wide = {1'b0, i_l & i_r};
            ALU_OR:
                wide = {1'b0, i_l | i_r};
            ALU_XOR:
                wide = {1'b0, i_l ^ i_r};
            // Bit shifted past the MSB lands in carry
            ALU_SHL:
                wide = {1'b0, i_l} << i_r[SHAMT_W-1:0];
            ALU_SHR:
                wide = {1'b0, i_l >> i_r[SHAMT_W-1:0]};
            ALU_PASS_R:
                wide = {1'b0, i_r};
            default:
                wide = '0;
        endcase
    end

    assign o_out = wide[RW-1:0];

    assign is_add = (i_mode == ALU_ADD) || (i_mode == ALU_ADC);
    assign is_sub = (i_mode == ALU_SUB) || (i_mode == ALU_SBC);

    // Signed overflow, sign of result differs from what operands allow
    assign ovf_add = (i_l[RW-1] == i_r[RW-1]) && (o_out[RW-1] != i_l[RW-1]);
    assign ovf_sub = (i_l[RW-1] != i_r[RW-1]) && (o_out[RW-1] != i_l[RW-1]);

    assign o_flags[FLAG_C] = wide[RW];
    assign o_flags[FLAG_Z] = ~|o_out;
    assign o_flags[FLAG_N] = o_out[RW-1];
    assign o_flags[FLAG_O] = (is_add & ovf_add) | (is_sub & ovf_sub);
    assign o_flags[FLAG_P] = ^o_out;

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

    // Datapath sizes
    localparam int RW         = 16;
    localparam int REGNO      = 8;
    localparam int REGNO_LOG  = 3;
    localparam int ALU_MODE_W = 4;

    // Flag vector layout
    localparam int FLAG_W = 5;
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_O = 3;
    localparam int FLAG_P = 4;

    // Jump condition field, top bit marks a jump
    localparam int JUMP_CODE_W = 5;
    localparam int JUMP_EN_BIT = 4;

    typedef enum logic [ALU_MODE_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SHL    = 4'd5,
        ALU_SHR    = 4'd6,
        ALU_PASS_R = 4'd7,
        ALU_ADC    = 4'd8,
        ALU_SBC    = 4'd9
    } alu_mode_e;

    typedef enum logic [JUMP_CODE_W-1:0] {
        JMP_NONE   = 5'b00000,
        JMP_UNCOND = 5'b10000,
        JMP_CARRY  = 5'b10001,
        JMP_EQ     = 5'b10010,
        JMP_LT     = 5'b10011,
        JMP_GT     = 5'b10100,
        JMP_LE     = 5'b10101,
        JMP_GE     = 5'b10110,
        JMP_NE     = 5'b10111,
        JMP_OVF    = 5'b11000,
        JMP_PAR    = 5'b11001
    } jump_code_e;

    // Decoded instruction as delivered by the decoder
    typedef struct packed {
        logic [RW-1:0]        imm;
        logic                 jmp_predict;
        logic                 pc_inc;
        logic                 pc_load;
        logic                 r_bus_imm;
        alu_mode_e            alu_mode;
        logic                 carry_en;
        logic                 flags_ie;
        logic [REGNO_LOG-1:0] l_sel;
        logic [REGNO_LOG-1:0] r_sel;
        logic [REGNO-1:0]     rf_ie;
        jump_code_e           jump_code;
        logic                 mem_access;
        logic                 mem_we;
        logic [1:0]           used_operands;
    } exec_ctrl_t;

    // Execute to memory stage
    typedef struct packed {
        logic [RW-1:0]    data;
        logic [RW-1:0]    addr;
        logic [REGNO-1:0] reg_ie;
        logic             mem_access;
        logic             mem_we;
    } stage_out_t;

    // Register writeback bus
    typedef struct packed {
        logic [REGNO-1:0] reg_ie;
        logic [RW-1:0]    data;
    } wb_t;

endpackage

// File: logic/exec_core.sv
module exec_core #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                   i_clk,
    input  logic                   i_rst,

    input  logic                   i_valid,
    output logic                   o_ready,
    input  cpu_pkg::exec_ctrl_t    i_ctrl,
    output logic                   o_flush,

    output logic                   o_pc_update,
    output logic [cpu_pkg::RW-1:0] o_exec_pc,
    output logic                   o_submit,

    // Writeback observation
    output logic                   o_wb_valid,
    output cpu_pkg::wb_t           o_wb
);
    import cpu_pkg::*;

    stage_out_t stage_out;
    logic       mem_ready;

    execute u_execute (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_ctrl       (i_ctrl),
        .o_flush      (o_flush),
        .o_pc_update  (o_pc_update),
        .o_exec_pc    (o_exec_pc),
        .o_submit     (o_submit),
        .o_out        (stage_out),
        .i_next_ready (mem_ready),
        .i_wb         (o_wb)
    );

    mem_stage #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem_stage (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_submit   (o_submit),
        .i_in       (stage_out),
        .o_ready    (mem_ready),
        .o_wb_valid (o_wb_valid),
        .o_wb       (o_wb)
    );

endmodule

// File: logic/execute.sv
module execute (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // Decoder handshake
    input  logic                   i_valid,
    output logic                   o_ready,
    input  cpu_pkg::exec_ctrl_t    i_ctrl,
    output logic                   o_flush,

    // PC report for the fetch side
    output logic                   o_pc_update,
    output logic [cpu_pkg::RW-1:0] o_exec_pc,

    // Next stage
    output logic                   o_submit,
    output cpu_pkg::stage_out_t    o_out,
    input  logic                   i_next_ready,
    input  cpu_pkg::wb_t           i_wb
);
    import cpu_pkg::*;

    logic              next_ready_dly;
    logic              out_pending;
    logic              l_busy;
    logic              r_busy;
    logic              raw_hazard;
    logic              instr_valid;
    logic              exec_submit;

    logic [RW-1:0]     reg_l;
    logic [RW-1:0]     reg_r;
    logic [RW-1:0]     alu_r_bus;
    logic [RW-1:0]     alu_out;
    logic [FLAG_W-1:0] alu_flags;
    logic [FLAG_W-1:0] flags_q;

    logic [RW-1:0]     pc_q;
    logic              jump_valid;
    logic              jump_taken;
    logic              jump_mispredict;
    logic              pc_write;
    logic              pc_step;

    // Output register still holds a write that has not reached memory stage,
    // also true in the first cycle after downstream ready rises
    assign out_pending = o_submit | ~next_ready_dly;

    // A write on the writeback bus lands only at the end of this cycle
    assign l_busy = (o_out.reg_ie[i_ctrl.l_sel] & out_pending) | i_wb.reg_ie[i_ctrl.l_sel];
    assign r_busy = (o_out.reg_ie[i_ctrl.r_sel] & out_pending) | i_wb.reg_ie[i_ctrl.r_sel];

    assign raw_hazard = (i_ctrl.used_operands[0] & l_busy) |
                        (i_ctrl.used_operands[1] & r_busy);

    // Instruction arriving under flush is dropped but still accepted
    assign instr_valid = i_valid & ~o_flush;
    assign exec_submit = i_next_ready & instr_valid & ~raw_hazard;
    assign o_ready     = exec_submit | ~instr_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            next_ready_dly <= 1'b0;
        end else begin
            next_ready_dly <= i_next_ready;
        end
    end

    reg_file u_reg_file (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_d    (i_wb.data),
        .i_ie   (i_wb.reg_ie),
        .i_lsel (i_ctrl.l_sel),
        .i_rsel (i_ctrl.r_sel),
        .o_l    (reg_l),
        .o_r    (reg_r)
    );

    assign alu_r_bus = i_ctrl.r_bus_imm ? i_ctrl.imm : reg_r;

    alu u_alu (
        .i_l     (reg_l),
        .i_r     (alu_r_bus),
        .i_mode  (i_ctrl.alu_mode),
        .i_carry (flags_q[FLAG_C] & i_ctrl.carry_en),
        .o_out   (alu_out),
        .o_flags (alu_flags)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (exec_submit && i_ctrl.flags_ie) begin
            flags_q <= alu_flags;
        end
    end

    // Jump condition against stored flags
    assign jump_valid = i_ctrl.jump_code[JUMP_EN_BIT];

    always_comb begin
        case (i_ctrl.jump_code)
            JMP_UNCOND: jump_taken = 1'b1;
            JMP_CARRY:  jump_taken = flags_q[FLAG_C];
            JMP_EQ:     jump_taken = flags_q[FLAG_Z];
            JMP_LT:     jump_taken = flags_q[FLAG_N];
            JMP_GT:     jump_taken = ~(flags_q[FLAG_N] | flags_q[FLAG_Z]);
            JMP_LE:     jump_taken = flags_q[FLAG_N] | flags_q[FLAG_Z];
            JMP_GE:     jump_taken = ~flags_q[FLAG_N];
            JMP_NE:     jump_taken = ~flags_q[FLAG_Z];
            JMP_OVF:    jump_taken = flags_q[FLAG_O];
            JMP_PAR:    jump_taken = flags_q[FLAG_P];
            default:    jump_taken = 1'b0;
        endcase
    end

    assign jump_mispredict = jump_valid & (jump_taken ^ i_ctrl.jmp_predict);

    // Kill whatever the decoder sends in the next cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= jump_mispredict & exec_submit;
        end
    end

    // Jump target comes through the ALU as pass_r of imm
    assign pc_write = i_ctrl.pc_load | (jump_valid & jump_taken);
    assign pc_step  = i_ctrl.pc_inc | jump_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= '0;
        end else if (exec_submit) begin
            if (pc_write) begin
                pc_q <= alu_out;
            end else if (pc_step) begin
                pc_q <= pc_q + RW'(1);
            end
        end
    end

    assign o_pc_update = exec_submit;
    assign o_exec_pc   = pc_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit          <= 1'b0;
            o_out.reg_ie      <= '0;
            o_out.mem_access  <= 1'b0;
            o_out.mem_we      <= 1'b0;
        end else begin
            o_submit <= exec_submit;
            if (exec_submit) begin
                // Stores carry the right register as data
                o_out.data       <= i_ctrl.mem_access ? reg_r : alu_out;
                o_out.addr       <= alu_out;
                o_out.reg_ie     <= i_ctrl.rf_ie;
                o_out.mem_access <= i_ctrl.mem_access;
                o_out.mem_we     <= i_ctrl.mem_we;
            end
        end
    end

endmodule

// File: logic/mem_stage.sv
module mem_stage #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_submit,
    input  cpu_pkg::stage_out_t i_in,
    output logic                o_ready,
    output logic                o_wb_valid,
    output cpu_pkg::wb_t        o_wb
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    logic [RW-1:0]     mem [MEM_DEPTH];
    logic [ADDR_W-1:0] mem_idx;
    logic              is_store;
    logic              wb_next;
    logic [REGNO-1:0]  wb_reg_ie;
    logic [RW-1:0]     wb_data;

    // Address wraps at the RAM size
    assign mem_idx  = i_in.addr[ADDR_W-1:0];
    assign is_store = i_submit & i_in.mem_access & i_in.mem_we;
    assign wb_next  = i_submit & ~is_store;

    // Single cycle access, never stalls execute
    assign o_ready = 1'b1;

    always_ff @(posedge i_clk) begin
        if (is_store) begin
            mem[mem_idx] <= i_in.data;
        end
        if (i_submit) begin
            wb_data <= i_in.mem_access ? mem[mem_idx] : i_in.data;
        end
    end

    // Enables go straight to the register file, so zero them when idle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_valid <= 1'b0;
            wb_reg_ie  <= '0;
        end else begin
            o_wb_valid <= wb_next;
            wb_reg_ie  <= wb_next ? i_in.reg_ie : '0;
        end
    end

    assign o_wb.reg_ie = wb_reg_ie;
    assign o_wb.data   = wb_data;

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic [cpu_pkg::RW-1:0]        i_d,
    input  logic [cpu_pkg::REGNO-1:0]     i_ie,
    input  logic [cpu_pkg::REGNO_LOG-1:0] i_lsel,
    input  logic [cpu_pkg::REGNO_LOG-1:0] i_rsel,
    output logic [cpu_pkg::RW-1:0]        o_l,
    output logic [cpu_pkg::RW-1:0]        o_r
);
    import cpu_pkg::*;

    logic [RW-1:0] regs [REGNO];

    // Each enable bit writes its own register, several may fire at once
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < REGNO; i++) begin
            if (i_rst) begin
                regs[i] <= '0;
            end else if (i_ie[i]) begin
                regs[i] <= i_d;
            end
        end
    end

    // Asynchronous read ports
    assign o_l = regs[i_lsel];
    assign o_r = regs[i_rsel];

endmodule

// File: tests/exec_checker.sv
module exec_checker #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_valid,
    input  logic                   i_ready,
    input  cpu_pkg::exec_ctrl_t    i_ctrl,
    input  logic                   i_flush,
    input  logic                   i_pc_update,
    input  logic [cpu_pkg::RW-1:0] i_exec_pc,
    input  logic                   i_submit,
    input  logic                   i_wb_valid,
    input  cpu_pkg::wb_t           i_wb,
    output int                     o_errors,
    output int                     o_checks,
    output int                     o_pending
);
    import cpu_pkg::*;

    logic [RW-1:0]     regs [REGNO];
    logic [RW-1:0]     mem [MEM_DEPTH];
    logic [FLAG_W-1:0] flags;
    logic [RW-1:0]     pc;
    logic              flush_due;
    logic              submit_due;
    logic              wb_next_due;
    logic              wb_due;
    logic [REGNO-1:0]  busy_out;
    logic [REGNO-1:0]  busy_wb;
    logic [REGNO-1:0]  busy;
    logic              hold;
    logic              exp_ready;
    logic              exp_issue;
    wb_t               exp_q [$];
    int                err_cnt;
    int                chk_cnt;

    // Reference ALU from the instruction set rules
    function automatic logic [RW-1:0] model_alu(input logic [RW-1:0] l, input logic [RW-1:0] r,
                                                input alu_mode_e mode, input logic cin,
                                                output logic [FLAG_W-1:0] f);
        logic [31:0] w;
        logic        c;
        logic        ov;
        int          sl;
        int          sr;
        int          cv;
        int          s;
        w = '0;
        c = 1'b0;
        ov = 1'b0;
        sl = int'($signed(l));
        sr = int'($signed(r));
        cv = (mode == ALU_ADC || mode == ALU_SBC) ? int'(cin) : 0;
        case (mode)
            ALU_ADD, ALU_ADC: begin
                w = 32'(l) + 32'(r) + 32'(cv);
                c = w[16];
                s = sl + sr + cv;
                ov = (s > 32767) || (s < -32768);
            end
            ALU_SUB, ALU_SBC: begin
                w = 32'(l) - 32'(r) - 32'(cv);
                // Borrow out
                c = (int'(l) - int'(r) - cv) < 0;
                s = sl - sr - cv;
                ov = (s > 32767) || (s < -32768);
            end
            ALU_AND:    w = 32'(l & r);
            ALU_OR:     w = 32'(l | r);
            ALU_XOR:    w = 32'(l ^ r);
            ALU_SHL: begin
                w = 32'(l) << r[3:0];
                c = w[16];
            end
            ALU_SHR:    w = 32'(l >> r[3:0]);
            ALU_PASS_R: w = 32'(r);
            default:    w = '0;
        endcase
        f[FLAG_C] = c;
        f[FLAG_Z] = (w[15:0] == 16'h0);
        f[FLAG_N] = w[15];
        f[FLAG_O] = ov;
        f[FLAG_P] = ^w[15:0];
        return w[15:0];
    endfunction

    function automatic logic cond_taken(input jump_code_e code, input logic [FLAG_W-1:0] f);
        case (code)
            JMP_UNCOND: return 1'b1;
            JMP_CARRY:  return f[FLAG_C];
            JMP_EQ:     return f[FLAG_Z];
            JMP_LT:     return f[FLAG_N];
            JMP_GT:     return !f[FLAG_N] && !f[FLAG_Z];
            JMP_LE:     return f[FLAG_N] || f[FLAG_Z];
            JMP_GE:     return !f[FLAG_N];
            JMP_NE:     return !f[FLAG_Z];
            JMP_OVF:    return f[FLAG_O];
            JMP_PAR:    return f[FLAG_P];
            default:    return 1'b0;
        endcase
    endfunction

    function automatic void report_wrong(input string msg);
        err_cnt++;
        $display("FAILED at %0t: %s", $time, msg);
    endfunction

    // One issued instruction through the model, in program order
    task automatic model_issue();
        logic [RW-1:0]     rr;
        logic [RW-1:0]     res;
        logic [RW-1:0]     data;
        logic [FLAG_W-1:0] nf;
        logic              jv;
        logic              taken;
        wb_t               w;
        rr = regs[i_ctrl.r_sel];
        res = model_alu(regs[i_ctrl.l_sel], i_ctrl.r_bus_imm ? i_ctrl.imm : rr,
                        i_ctrl.alu_mode, flags[FLAG_C] & i_ctrl.carry_en, nf);
        jv = i_ctrl.jump_code[JUMP_EN_BIT];
        taken = jv && cond_taken(i_ctrl.jump_code, flags);
        chk_cnt++;
        if (i_exec_pc !== pc) begin
            report_wrong($sformatf("exec pc %h, expected %h", i_exec_pc, pc));
        end
        if (i_ctrl.pc_load || taken) begin
            pc = res;
        end else if (i_ctrl.pc_inc || jv) begin
            pc = pc + 16'd1;
        end
        if (i_ctrl.flags_ie) begin
            flags = nf;
        end
        flush_due = jv && (taken != i_ctrl.jmp_predict);
        submit_due = 1'b1;
        if (i_ctrl.mem_access && i_ctrl.mem_we) begin
            mem[int'(res) % MEM_DEPTH] = rr;
        end else begin
            data = i_ctrl.mem_access ? mem[int'(res) % MEM_DEPTH] : res;
            w.reg_ie = i_ctrl.rf_ie;
            w.data = data;
            exp_q.push_back(w);
            wb_next_due = 1'b1;
            busy_out = i_ctrl.rf_ie;
            for (int i = 0; i < REGNO; i++) begin
                if (i_ctrl.rf_ie[i]) begin
                    regs[i] = data;
                end
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REGNO; i++) begin
                regs[i] = '0;
            end
            flags = '0;
            pc = '0;
            flush_due = 1'b0;
            submit_due = 1'b0;
            wb_next_due = 1'b0;
            wb_due = 1'b0;
            busy_out = '0;
            busy_wb = '0;
            exp_q.delete();
        end else begin
            chk_cnt++;
            if (i_flush !== flush_due) begin
                report_wrong($sformatf("flush %b, expected %b", i_flush, flush_due));
            end
            // A source register with a write still in flight holds the instruction
            busy = busy_out | busy_wb;
            hold = (i_ctrl.used_operands[0] && busy[i_ctrl.l_sel]) ||
                   (i_ctrl.used_operands[1] && busy[i_ctrl.r_sel]);
            exp_ready = !i_valid || flush_due || !hold;
            exp_issue = i_valid && exp_ready && !flush_due;
            if (i_ready !== exp_ready) begin
                report_wrong($sformatf("ready %b, expected %b", i_ready, exp_ready));
            end
            if (i_pc_update !== exp_issue) begin
                report_wrong($sformatf("issue %b, expected %b", i_pc_update, exp_issue));
            end
            if (i_submit !== submit_due) begin
                report_wrong($sformatf("submit %b, expected %b", i_submit, submit_due));
            end
            if (i_wb_valid !== wb_due) begin
                report_wrong($sformatf("wb valid %b, expected %b", i_wb_valid, wb_due));
            end
            flush_due = 1'b0;
            wb_due = wb_next_due;
            busy_wb = busy_out;
            busy_out = '0;
            submit_due = 1'b0;
            wb_next_due = 1'b0;
            if (i_pc_update) begin
                model_issue();
            end
            if (i_wb_valid) begin
                chk_cnt++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Writeback seen with no instruction outstanding");
                end else if (i_wb !== exp_q[0]) begin
                    report_wrong($sformatf("wb %h/%h, expected %h/%h", i_wb.reg_ie,
                                           i_wb.data, exp_q[0].reg_ie, exp_q[0].data));
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
            end
        end
        o_errors  <= err_cnt;
        o_checks  <= chk_cnt;
        o_pending <= exp_q.size();
    end

    initial begin
        err_cnt = 0;
        chk_cnt = 0;
    end

endmodule

// File: tests/tb_exec_core.sv
module tb_exec_core;
    import cpu_pkg::*;

    localparam int MEM_DEPTH = 256;
    localparam int N_ALU   = 160;
    localparam int N_CARRY = 120;
    localparam int N_RAW   = 120;
    localparam int N_JUMP  = 160;
    localparam int N_JUMP_ALL = N_JUMP + N_JUMP / 2;
    localparam int N_FILL  = 2 * MEM_DEPTH;
    localparam int N_MEM   = 160;
    localparam int LIMIT   = (N_ALU + N_CARRY + N_RAW + N_JUMP_ALL + N_FILL + N_MEM) * 4 + 100;

    logic          i_clk;
    logic          i_rst;
    logic          valid;
    exec_ctrl_t    ctrl;
    logic          ready;
    logic          flush;
    logic          pc_update;
    logic [RW-1:0] exec_pc;
    logic          submit;
    logic          wb_valid;
    wb_t           wb;
    int            errors;
    int            checks;
    int            pending;

    logic [31:0]   lfsr;
    int            cycles;
    int            stalls;
    int            tb_errors;
    int            tests_run;
    int            tests_failed;
    logic [2:0]    last_dst;

    jump_code_e    jump_codes [10] = '{JMP_UNCOND, JMP_CARRY, JMP_EQ, JMP_LT, JMP_GT,
                                       JMP_LE, JMP_GE, JMP_NE, JMP_OVF, JMP_PAR};

    exec_core #(
        .MEM_DEPTH (MEM_DEPTH)
    ) UUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (valid),
        .o_ready     (ready),
        .i_ctrl      (ctrl),
        .o_flush     (flush),
        .o_pc_update (pc_update),
        .o_exec_pc   (exec_pc),
        .o_submit    (submit),
        .o_wb_valid  (wb_valid),
        .o_wb        (wb)
    );

    exec_checker #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_checker (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (valid),
        .i_ready     (ready),
        .i_ctrl      (ctrl),
        .i_flush     (flush),
        .i_pc_update (pc_update),
        .i_exec_pc   (exec_pc),
        .i_submit    (submit),
        .i_wb_valid  (wb_valid),
        .i_wb        (wb),
        .o_errors    (errors),
        .o_checks    (checks),
        .o_pending   (pending)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic exec_ctrl_t plain_ctrl();
        exec_ctrl_t c;
        c = '0;
        c.alu_mode = ALU_ADD;
        c.jump_code = JMP_NONE;
        c.pc_inc = 1'b1;
        c.used_operands = 2'b11;
        return c;
    endfunction

    function automatic exec_ctrl_t rand_alu(input logic carry_modes);
        exec_ctrl_t c;
        logic [2:0] dst;
        c = plain_ctrl();
        if (carry_modes) begin
            case (2'(rand_bits(2)))
                2'd0: c.alu_mode = ALU_ADD;
                2'd1: c.alu_mode = ALU_SUB;
                2'd2: c.alu_mode = ALU_ADC;
                default: c.alu_mode = ALU_SBC;
            endcase
        end else begin
            c.alu_mode = alu_mode_e'(4'(rand_bits(3)));
        end
        c.l_sel = 3'(rand_bits(3));
        c.r_sel = 3'(rand_bits(3));
        c.r_bus_imm = 1'(rand_bits(1));
        // Only registers the operation actually reads
        c.used_operands[0] = (c.alu_mode != ALU_PASS_R);
        c.used_operands[1] = ~c.r_bus_imm;
        c.imm = 16'(rand_bits(16));
        c.flags_ie = 1'(rand_bits(1));
        c.carry_en = 1'(rand_bits(1));
        dst = 3'(rand_bits(3));
        c.rf_ie = (3'(rand_bits(3)) == 3'd0) ? 8'h00 : 8'h01 << dst;
        return c;
    endfunction

    function automatic exec_ctrl_t mem_op(input logic store, input logic [RW-1:0] addr,
                                          input logic [2:0] reg_sel);
        exec_ctrl_t c;
        c = plain_ctrl();
        c.alu_mode = ALU_PASS_R;
        c.r_bus_imm = 1'b1;
        c.imm = addr;
        c.mem_access = 1'b1;
        c.mem_we = store;
        c.r_sel = reg_sel;
        c.rf_ie = store ? 8'h00 : 8'h01 << reg_sel;
        return c;
    endfunction

    // Present one instruction and wait for the handshake
    task automatic issue(input exec_ctrl_t c);
        valid <= 1'b1;
        ctrl <= c;
        @(posedge i_clk);
        while (!ready) begin
            stalls++;
            @(posedge i_clk);
        end
    endtask

    task automatic finish_test(input string name, input int n, input int errs_before);
        valid <= 1'b0;
        repeat (4) @(posedge i_clk);
        while (pending != 0) begin
            @(posedge i_clk);
        end
        repeat (2) @(posedge i_clk);
        tests_run++;
        if (errors + tb_errors != errs_before) begin
            tests_failed++;
        end
        $display("test %-8s %4d instructions, %0d errors", name, n,
                 errors + tb_errors - errs_before);
    endtask

    initial begin
        exec_ctrl_t c;
        int         e0;
        lfsr = 32'h96b7;
        cycles = 0;
        stalls = 0;
        tb_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        last_dst = 3'd0;
        valid = 1'b0;
        ctrl = '0;
        i_rst = 1'b1;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);

        // Registers read as zero until written
        e0 = errors + tb_errors;
        for (int i = 0; i < N_ALU; i++) begin
            issue(rand_alu(1'b0));
        end
        finish_test("alu", N_ALU, e0);

        e0 = errors + tb_errors;
        for (int i = 0; i < N_CARRY; i++) begin
            issue(rand_alu(1'b1));
        end
        finish_test("carry", N_CARRY, e0);

        e0 = errors + tb_errors;
        stalls = 0;
        for (int i = 0; i < N_RAW; i++) begin
            c = rand_alu(1'b0);
            c.l_sel = last_dst;
            if (rand_bits(1) != 0) begin
                c.r_sel = last_dst;
            end
            last_dst = 3'(rand_bits(3));
            c.rf_ie = 8'h01 << last_dst;
            issue(c);
        end
        if (stalls == 0) begin
            tb_errors++;
            $display("Dependent instructions never saw o_ready drop");
        end
        finish_test("raw", N_RAW, e0);

        // Each jump is followed by a shadow that a mispredict must kill
        e0 = errors + tb_errors;
        for (int i = 0; i < N_JUMP; i += 2) begin
            c = rand_alu(1'b0);
            c.flags_ie = 1'b1;
            issue(c);
            c = plain_ctrl();
            c.jump_code = jump_codes[int'(rand_bits(8)) % 10];
            c.jmp_predict = 1'(rand_bits(1));
            c.alu_mode = ALU_PASS_R;
            c.r_bus_imm = 1'b1;
            c.imm = 16'(rand_bits(16));
            issue(c);
            issue(rand_alu(1'b0));
        end
        finish_test("jump", N_JUMP_ALL, e0);

        e0 = errors + tb_errors;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            c = plain_ctrl();
            c.alu_mode = ALU_PASS_R;
            c.r_bus_imm = 1'b1;
            c.imm = {a[7:0], ~a[7:0]} ^ 16'h5a3c;
            c.rf_ie = 8'h08;
            issue(c);
            issue(mem_op(1'b1, RW'(a), 3'd3));
        end
        finish_test("fill", N_FILL, e0);

        e0 = errors + tb_errors;
        for (int i = 0; i < N_MEM; i++) begin
            case (2'(rand_bits(2)))
                2'd0: issue(rand_alu(1'b0));
                2'd1: issue(mem_op(1'b1, 16'(rand_bits(16)), 3'(rand_bits(3))));
                default: issue(mem_op(1'b0, 16'(rand_bits(16)), 3'(rand_bits(3))));
            endcase
        end
        finish_test("memory", N_MEM, e0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                 checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
